// File: tb.f
+incdir+tests
design/defines.sv
design/pc_adder.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/core_apb_ctrl.sv
design/branch_core_top.sv
tests/tb_branch_core.sv

// File: run.sh
#!/bin/bash
# build with verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_branch_core -f tb.f -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| echo "build or simulation did not complete"
cat sim.log 2>/dev/null
if [ ! -f sim.log ] || grep -q "Test failures found" sim.log; then
	exit 1
fi
grep -q "All tests passed!" sim.log || exit 1
exit 0

// File: tests/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam data_t ECALL_WORD = 32'h0000_0073;
localparam int STEP_LIMIT = 4000; // model gives up after this many instructions

function automatic int unsigned next_rand();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// encoders, rv32i field layout
function automatic data_t enc_r(input logic [6:0] f7, input int rd, input int rs1, input int rs2);
	return {f7, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'h33};
endfunction

function automatic data_t enc_addi(input int rd, input int rs1, input int imm);
	return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'h13};
endfunction

function automatic data_t enc_jalr(input int rd, input int rs1, input int imm);
	return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'h67};
endfunction

function automatic data_t enc_lui(input int rd, input int unsigned imm20);
	return {20'(imm20), 5'(rd), 7'h37};
endfunction

function automatic data_t enc_branch(input logic [2:0] f3, input int rs1, input int rs2,
		input int off);
	logic [12:0] o;
	o = 13'(off);
	return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'h63};
endfunction

function automatic data_t enc_jal(input int rd, input int off);
	logic [20:0] o;
	o = 21'(off);
	return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'h6f};
endfunction

function automatic void write_reg(input logic [4:0] rd, input data_t v);
	if (rd != 5'd0)
		model_rf[rd] = v;
endfunction

// plain isa interpreter, one instruction per step, stops on ecall
task automatic run_model(output bit done);
	data_t pc, ins, a, b, nxt;
	logic [4:0] rd;
	logic take;
	int imm;
	int off;
	int steps;
	done = 1'b0;
	pc = '0;
	steps = 0;
	while (!done && steps < STEP_LIMIT) begin
		ins = model_mem[pc[7:2]];
		rd = ins[11:7];
		a = model_rf[ins[19:15]];
		b = model_rf[ins[24:20]];
		imm = int'($signed(ins[31:20]));
		nxt = pc + 32'd4;
		take = 1'b0;
		case (ins[6:0])
			7'h33: begin
				if (ins[14:12] == 3'b000 && ins[31:25] == 7'h00)
					write_reg(rd, a + b);
				else if (ins[14:12] == 3'b000 && ins[31:25] == 7'h20)
					write_reg(rd, a - b);
			end
			7'h13: begin
				if (ins[14:12] == 3'b000)
					write_reg(rd, a + imm);
			end
			7'h37: write_reg(rd, {ins[31:12], 12'h000});
			7'h63: begin
				case (ins[14:12])
					3'b000: take = (a == b);
					3'b001: take = (a != b);
					3'b100: take = ($signed(a) < $signed(b));
					3'b101: take = ($signed(a) >= $signed(b));
					3'b110: take = (a < b);
					3'b111: take = (a >= b);
					default: take = 1'b0;
				endcase
				off = int'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
				if (take)
					nxt = pc + off;
			end
			7'h6f: begin
				off = int'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
				write_reg(rd, pc + 32'd4);
				nxt = pc + off;
			end
			7'h67: begin
				nxt = (a + imm) & ~32'd1; // target taken before the link write
				write_reg(rd, pc + 32'd4);
			end
			7'h73: done = (ins == ECALL_WORD);
			default: ;
		endcase
		pc = nxt;
		steps++;
	end
endtask

`endif

// File: tests/tb_branch_core.sv
`timescale 1ns/1ps

module tb_branch_core;
	import defines::*;

	localparam int POLL_LIMIT = 400;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [11:0] paddr;
	data_t pwdata;
	data_t prdata;
	logic pready;
	logic pslverr;

	int errors;
	int checks;
	int test_errors;
	int unsigned lcg_state;
	data_t prog [$];
	data_t model_mem [IMEM_WORDS];
	data_t model_rf [32];

	`include "tb_ref_model.svh"

	branch_core_top u_branch_core_top (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	always #50 clk = ~clk;

	task automatic check_val(input string name, input data_t got, input data_t exp);
		checks++;
		assert (got === exp) else begin
			$display("FAIL %0t %s got %08h expected %08h", $time, name, got, exp);
			errors++;
		end
	endtask

	// setup cycle, access cycle, then one idle cycle
	task automatic apb_access(input logic wr, input logic [11:0] addr, input data_t wdata,
			output data_t rdata, output logic err);
		int n;
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		n = 0;
		while (!pready && n < 8) begin
			@(negedge clk);
			n++;
		end
		if (!pready) begin
			$display("no pready on APB access to address %03h", addr);
			errors++;
		end
		rdata = prdata; // sampled mid access cycle
		err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [11:0] addr, input data_t data, input logic exp_err);
		data_t unused;
		logic err;
		apb_access(1'b1, addr, data, unused, err);
		check_val($sformatf("pslverr wr %03h", addr), {31'b0, err}, {31'b0, exp_err});
	endtask

	task automatic apb_read(input logic [11:0] addr, input logic exp_err, output data_t data);
		logic err;
		apb_access(1'b0, addr, NULL, data, err);
		check_val($sformatf("pslverr rd %03h", addr), {31'b0, err}, {31'b0, exp_err});
	endtask

	task automatic load_program();
		int i;
		for (i = 0; i < prog.size(); i++) begin
			apb_write(IMEM_BASE + 12'(4 * i), prog[i], 1'b0);
			model_mem[i] = prog[i];
		end
	endtask

	task automatic start_core();
		apb_write(CTRL_ADDR, 32'h1, 1'b0);
	endtask

	task automatic wait_halt();
		data_t st;
		int n;
		n = 0;
		st = NULL;
		while (st[1] !== 1'b1 && n < POLL_LIMIT) begin
			apb_read(STATUS_ADDR, 1'b0, st);
			n++;
		end
		if (st[1] !== 1'b1) begin
			$display("core did not halt within %0d status polls", POLL_LIMIT);
			errors++;
		end
	endtask

	task automatic compare_regs();
		data_t v;
		int i;
		for (i = 0; i < 32; i++) begin
			apb_read(REG_BASE + 12'(4 * i), 1'b0, v);
			check_val($sformatf("x%0d", i), v, model_rf[i]);
		end
	endtask

	task automatic finish_run();
		bit done;
		wait_halt();
		run_model(done);
		if (!done) begin
			$display("reference model reached its step limit without ecall");
			errors++;
		end
		compare_regs();
	endtask

	task automatic run_and_check();
		load_program();
		start_core();
		finish_run();
	endtask

	task automatic report_test(input string name);
		if (errors == test_errors)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	task automatic test_reset_apb();
		data_t v;
		data_t w;
		int i;
		apb_read(STATUS_ADDR, 1'b0, v);
		check_val("status", v, NULL);
		// clearing program doubles as the imem readback data
		prog.delete();
		for (i = 1; i < 32; i++)
			prog.push_back(enc_addi(i, 0, 0));
		prog.push_back(ECALL_WORD);
		load_program();
		for (i = 0; i < prog.size(); i++) begin
			apb_read(IMEM_BASE + 12'(4 * i), 1'b0, v);
			check_val($sformatf("imem[%0d]", i), v, prog[i]);
		end
		for (i = 32; i < IMEM_WORDS; i++) begin
			w = next_rand();
			apb_write(IMEM_BASE + 12'(4 * i), w, 1'b0);
			apb_read(IMEM_BASE + 12'(4 * i), 1'b0, v);
			check_val($sformatf("imem[%0d]", i), v, w);
		end
		apb_read(12'h200, 1'b1, v);
		apb_read(12'h102, 1'b1, v);
		apb_write(12'h108, 32'h1, 1'b1);
		apb_write(STATUS_ADDR, 32'h3, 1'b1);
		apb_write(REG_BASE + 12'h008, 32'h55, 1'b1);
		start_core();
		apb_write(IMEM_BASE, NULL, 1'b1); // refused while running
		finish_run();
		report_test("reset and apb");
	endtask

	task automatic test_alu_chain();
		int n, k;
		int rd, rs1, rs2;
		for (n = 0; n < 3; n++) begin
			prog.delete();
			if (n == 0) begin
				prog.push_back(enc_lui(1, 32'h8765_4));
				prog.push_back(enc_addi(1, 1, -7));     // ex forward
				prog.push_back(enc_r(7'h00, 2, 1, 1));  // both from ex
				prog.push_back(enc_r(7'h20, 3, 2, 1));  // ex and wb
				prog.push_back(enc_r(7'h00, 4, 1, 3));  // x1 from the file
			end
			for (k = 0; k < 48; k++) begin
				rd = 1 + int'(next_rand() % 6);
				rs1 = 1 + int'(next_rand() % 6);
				rs2 = 1 + int'(next_rand() % 6);
				case (next_rand() % 4)
					0: prog.push_back(enc_r(7'h00, rd, rs1, rs2));
					1: prog.push_back(enc_r(7'h20, rd, rs1, rs2));
					2: prog.push_back(enc_addi(rd, rs1, int'(next_rand() % 4096) - 2048));
					default: prog.push_back(enc_lui(rd, next_rand() >> 12));
				endcase
			end
			prog.push_back(ECALL_WORD);
			run_and_check();
		end
		report_test("alu chains");
	endtask

	task automatic test_branches();
		int f, p, k, c, ra, rb;
		int unsigned hi, hi2;
		logic [2:0] f3;
		for (f = 0; f < 6; f++) begin
			f3 = (f < 2) ? 3'(f) : 3'(f + 2); // beq bne blt bge bltu bgeu
			for (p = 0; p < 4; p++) begin
				prog.delete();
				for (k = 0; k < 5; k++)
					prog.push_back(enc_addi(10 + k, 0, 0)); // clear markers
				for (k = 0; k < 5; k++) begin
					c = p * 5 + k;
					ra = (c % 2 == 1) ? 1 : 2; // swap which operand comes last
					rb = 3 - ra;
					hi = next_rand() >> 12;
					prog.push_back(enc_lui(ra, hi));
					prog.push_back(enc_addi(ra, ra, int'(next_rand() % 4096) - 2048));
					if (c % 4 == 0)
						prog.push_back(enc_r(7'h00, rb, ra, 0)); // equal
					else if (c % 4 == 2)
						prog.push_back(enc_addi(rb, ra, int'(next_rand() % 5) - 2));
					else begin
						hi2 = next_rand() >> 12;
						if (c % 4 == 1)
							hi2 = (hi2 & 32'h7ffff) | (~hi & 32'h80000); // other sign
						prog.push_back(enc_lui(rb, hi2));
						prog.push_back(enc_addi(rb, rb, int'(next_rand() % 4096) - 2048));
					end
					prog.push_back(enc_branch(f3, 1, 2, 8));
					prog.push_back(enc_addi(10 + k, 0, c + 1)); // skipped when taken
				end
				prog.push_back(ECALL_WORD);
				run_and_check();
			end
		end
		report_test("branches");
	endtask

	task automatic test_jumps();
		prog.delete();
		prog.push_back(enc_addi(6, 0, 0));
		prog.push_back(enc_addi(7, 0, 0));
		prog.push_back(enc_addi(9, 0, 0));
		prog.push_back(enc_jal(1, 12));          // 12 -> 24
		prog.push_back(enc_addi(6, 0, 1));
		prog.push_back(enc_addi(6, 0, 2));
		prog.push_back(enc_addi(2, 0, 41));      // odd base
		prog.push_back(enc_jalr(3, 2, 0));       // 28 -> 40
		prog.push_back(enc_addi(7, 0, 1));
		prog.push_back(enc_addi(7, 0, 2));
		prog.push_back(enc_r(7'h00, 12, 1, 3));
		prog.push_back(enc_jalr(8, 1, 45));      // 16 + 45 odd, lands on 60
		prog.push_back(enc_addi(9, 0, 1));
		prog.push_back(enc_addi(9, 0, 2));
		prog.push_back(enc_addi(9, 0, 3));
		prog.push_back(enc_jal(0, 8));           // no link
		prog.push_back(enc_addi(9, 0, 4));
		prog.push_back(enc_jal(11, 16));         // 68 -> 84
		prog.push_back(ECALL_WORD);
		prog.push_back(enc_addi(9, 0, 5));
		prog.push_back(enc_addi(9, 0, 6));
		prog.push_back(enc_jalr(13, 11, 0));     // back to the ecall at 72
		prog.push_back(ECALL_WORD);
		run_and_check();
		report_test("jumps");
	endtask

	task automatic test_halt_x0();
		data_t v;
		int i;
		prog.delete();
		prog.push_back(enc_addi(16, 0, 0));
		prog.push_back(enc_addi(0, 0, 5));
		prog.push_back(enc_lui(0, 32'h12345));
		prog.push_back(enc_r(7'h00, 13, 0, 0));  // x0 must not forward
		prog.push_back(enc_addi(14, 0, 7));
		prog.push_back(enc_r(7'h00, 0, 14, 14));
		prog.push_back(enc_r(7'h00, 15, 0, 14));
		prog.push_back(ECALL_WORD);
		prog.push_back(enc_addi(16, 0, 9));      // behind the ecall
		prog.push_back(ECALL_WORD);
		run_and_check();
		apb_read(STATUS_ADDR, 1'b0, v);
		check_val("status", v, 32'h2);
		for (i = 0; i < 8; i++) begin
			apb_read(STATUS_ADDR, 1'b0, v);
			check_val("status", v, 32'h2);
		end
		compare_regs();
		start_core();
		apb_read(STATUS_ADDR, 1'b0, v);
		check_val("status", v, 32'h1);
		finish_run();
		report_test("halt and x0");
	endtask

	initial begin
		int i;
		clk = 1'b0;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = NULL;
		errors = 0;
		checks = 0;
		test_errors = 0;
		lcg_state = 56516;
		for (i = 0; i < IMEM_WORDS; i++)
			model_mem[i] = ECALL_WORD;
		for (i = 0; i < 32; i++)
			model_rf[i] = NULL;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		test_reset_apb();
		test_alu_chain();
		test_branches();
		test_jumps();
		test_halt_x0();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// whole-run limit
	initial begin
		#20_000_000;
		$display("simulation time limit reached before the sequence ended");
		$display("Test failures found");
		$finish;
	end

endmodule

// File: design/branch_core_top.sv
`timescale 1ns/1ps

module branch_core_top (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [11:0] paddr,
	input defines::data_t pwdata,
	output defines::data_t prdata,
	output logic pready,
	output logic pslverr
);
	import defines::*;

	data_t pc, pc_bj;
	instr_t fetch_instr;
	logic fetch_valid, flush, pc_sel, halt_seen;
	reg_addr_t host_addr, rs1_addr, rs2_addr;
	data_t host_rdata, rs1_data, rs2_data;
	logic id_valid, id_we;
	alu_op_t id_alu_op;
	reg_addr_t id_rd;
	data_t id_op_a, id_op_b;
	reg_addr_t ex_rd, wb_rd;
	logic ex_we, wb_we;
	data_t ex_data, wb_data;

	core_apb_ctrl u_core_apb_ctrl (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.halt_seen(halt_seen), .pc_sel(pc_sel), .pc_bj(pc_bj),
		.pc(pc), .fetch_instr(fetch_instr), .fetch_valid(fetch_valid),
		.flush(flush), .host_addr(host_addr), .host_rdata(host_rdata)
	);

	decode_stage u_decode_stage (
		.clk(clk), .reset(reset), .flush(flush), .fetch_valid(fetch_valid),
		.pc(pc), .fetch_instr(fetch_instr),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.ex_data(ex_data), .wb_data(wb_data), .ex_rd(ex_rd), .wb_rd(wb_rd),
		.ex_we(ex_we), .wb_we(wb_we),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.pc_sel(pc_sel), .pc_bj(pc_bj), .halt_seen(halt_seen),
		.id_valid(id_valid), .id_alu_op(id_alu_op), .id_rd(id_rd), .id_we(id_we),
		.id_op_a(id_op_a), .id_op_b(id_op_b)
	);

	execute_stage u_execute_stage (
		.clk(clk), .reset(reset), .flush(flush),
		.id_valid(id_valid), .id_alu_op(id_alu_op), .id_rd(id_rd), .id_we(id_we),
		.id_op_a(id_op_a), .id_op_b(id_op_b),
		.ex_rd(ex_rd), .ex_we(ex_we), .ex_data(ex_data),
		.wb_rd(wb_rd), .wb_we(wb_we), .wb_data(wb_data)
	);

	result_stage u_result_stage (
		.clk(clk), .reset(reset),
		.wb_rd(wb_rd), .wb_we(wb_we), .wb_data(wb_data),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .host_addr(host_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .host_rdata(host_rdata)
	);

endmodule

// File: design/core_apb_ctrl.sv
`timescale 1ns/1ps

module core_apb_ctrl (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [11:0] paddr,
	input defines::data_t pwdata,
	output defines::data_t prdata,
	output logic pready,
	output logic pslverr,
	input logic halt_seen,
	input logic pc_sel,
	input defines::data_t pc_bj,
	output defines::data_t pc,
	output defines::instr_t fetch_instr,
	output logic fetch_valid,
	output logic flush,
	output defines::reg_addr_t host_addr,
	input defines::data_t host_rdata
);
	import defines::*;

	data_t imem [IMEM_WORDS];
	logic running, halted;
	logic access;
	logic [11:0] imem_off, reg_off;
	logic is_imem, is_ctrl, is_status, is_reg;
	logic bad;
	logic imem_we, ctrl_we;

	assign access = psel && penable;
	assign pready = access; // never waits

	assign imem_off = paddr - IMEM_BASE;
	assign reg_off = paddr - REG_BASE;
	assign is_imem = paddr[1:0] == 2'b00 && imem_off < 12'(IMEM_WORDS * 4);
	assign is_reg = paddr[1:0] == 2'b00 && reg_off < 12'(REGS * 4);
	assign is_ctrl = paddr == CTRL_ADDR;
	assign is_status = paddr == STATUS_ADDR;

	// unmapped, imem write while running, or write to a read-only location
	assign bad = !(is_imem || is_ctrl || is_status || is_reg)
		|| (pwrite && is_imem && running)
		|| (pwrite && (is_status || is_reg));
	assign pslverr = access && bad;

	assign imem_we = access && pwrite && !bad && is_imem;
	assign ctrl_we = access && pwrite && is_ctrl;
	assign flush = ctrl_we && pwdata[0]; // start strobe, one cycle
	assign host_addr = reg_off[6:2];

	always_comb begin
		prdata = NULL;
		if (access && !pwrite && !bad) begin
			if (is_imem)
				prdata = imem[imem_off[IMEM_AW+1:2]];
			else if (is_ctrl)
				prdata = {31'b0, running};
			else if (is_status)
				prdata = {30'b0, halted, running};
			else
				prdata = host_rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (imem_we)
			imem[imem_off[IMEM_AW+1:2]] <= pwdata;
	end

	assign fetch_instr = imem[pc[IMEM_AW+1:2]];
	assign fetch_valid = running;

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			halted <= 1'b0;
			pc <= NULL;
		end else if (ctrl_we) begin
			running <= pwdata[0];
			if (pwdata[0]) begin
				pc <= NULL;
				halted <= 1'b0;
			end
		end else if (running) begin
			pc <= pc_sel ? pc_bj : pc + 32'd4;
			if (halt_seen) begin // ecall in decode
				running <= 1'b0;
				halted <= 1'b1;
			end
		end
	end

endmodule

// File: design/result_stage.sv
`timescale 1ns/1ps

module result_stage (
	input logic clk,
	input logic reset,
	input defines::reg_addr_t wb_rd,
	input logic wb_we,
	input defines::data_t wb_data,
	input defines::reg_addr_t rs1_addr,
	input defines::reg_addr_t rs2_addr,
	input defines::reg_addr_t host_addr,
	output defines::data_t rs1_data,
	output defines::data_t rs2_data,
	output defines::data_t host_rdata
);
	import defines::*;

	data_t rf [1:REGS-1]; // x0 not stored

	// write-through so a same-cycle write is seen
	function automatic data_t read_reg(input reg_addr_t a);
		if (a == '0)
			return NULL;
		if (wb_we && wb_rd == a)
			return wb_data;
		return rf[a];
	endfunction

	always_ff @(posedge clk) begin
		if (!reset && wb_we && wb_rd != '0)
			rf[wb_rd] <= wb_data;
	end

	always_comb begin
		rs1_data = read_reg(rs1_addr);
		rs2_data = read_reg(rs2_addr);
		host_rdata = read_reg(host_addr);
	end

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic id_valid,
	input defines::alu_op_t id_alu_op,
	input defines::reg_addr_t id_rd,
	input logic id_we,
	input defines::data_t id_op_a,
	input defines::data_t id_op_b,
	output defines::reg_addr_t ex_rd,
	output logic ex_we,
	output defines::data_t ex_data,
	output defines::reg_addr_t wb_rd,
	output logic wb_we,
	output defines::data_t wb_data
);
	import defines::*;

	data_t alu_out;

	always_comb begin
		case (id_alu_op)
			ALU_ADD:    alu_out = id_op_a + id_op_b;
			ALU_SUB:    alu_out = id_op_a - id_op_b;
			ALU_PASS_B: alu_out = id_op_b;  // lui
			ALU_LINK:   alu_out = id_op_a + 32'd4;
			default:    alu_out = NULL;
		endcase
	end

	// visible to decode in the same cycle
	assign ex_rd = id_rd;
	assign ex_we = id_valid && id_we && (id_rd != '0);
	assign ex_data = alu_out;

	always_ff @(posedge clk) begin
		if (reset || flush)
			wb_we <= 1'b0;
		else
			wb_we <= ex_we;
		wb_rd <= ex_rd;
		wb_data <= alu_out;
	end

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic fetch_valid,
	input defines::data_t pc,
	input defines::instr_t fetch_instr,
	input defines::data_t rs1_data,
	input defines::data_t rs2_data,
	input defines::data_t ex_data,
	input defines::data_t wb_data,
	input defines::reg_addr_t ex_rd,
	input defines::reg_addr_t wb_rd,
	input logic ex_we,
	input logic wb_we,
	output defines::reg_addr_t rs1_addr,
	output defines::reg_addr_t rs2_addr,
	output logic pc_sel,
	output defines::data_t pc_bj,
	output logic halt_seen,
	output logic id_valid,
	output defines::alu_op_t id_alu_op,
	output defines::reg_addr_t id_rd,
	output logic id_we,
	output defines::data_t id_op_a,
	output defines::data_t id_op_b
);
	import defines::*;

	instr_t d_instr;
	data_t d_pc;
	logic d_valid;
	opcode_t opcode;
	branch_fwd_t fwd_rs1, fwd_rs2;
	data_t fa, fb;
	logic bj_sel;
	alu_op_t alu_op;
	logic we;
	data_t op_a, op_b;

	// execute wins over write-back, x0 never forwarded
	function automatic branch_fwd_t fwd_pick(
		input reg_addr_t r,
		input logic e_we,
		input reg_addr_t e_rd,
		input logic w_we,
		input reg_addr_t w_rd
	);
		if (r != '0 && e_we && e_rd == r)
			return B_EX_SEL;
		if (r != '0 && w_we && w_rd == r)
			return B_WB_SEL;
		return B_RS_SEL;
	endfunction

	always_ff @(posedge clk) begin
		if (reset || flush)
			d_valid <= 1'b0;
		else
			d_valid <= fetch_valid && !pc_sel && !halt_seen; // kill the wrong-path fetch
		d_instr <= fetch_instr;
		d_pc <= pc;
	end

	assign opcode = opcode_t'(d_instr.opcode);
	assign rs1_addr = d_instr.rs1;
	assign rs2_addr = d_instr.rs2;

	assign fwd_rs1 = fwd_pick(rs1_addr, ex_we, ex_rd, wb_we, wb_rd);
	assign fwd_rs2 = fwd_pick(rs2_addr, ex_we, ex_rd, wb_we, wb_rd);

	always_comb begin
		case (fwd_rs1)
			B_EX_SEL: fa = ex_data;
			B_WB_SEL: fa = wb_data;
			default:  fa = rs1_data;
		endcase
		case (fwd_rs2)
			B_EX_SEL: fb = ex_data;
			B_WB_SEL: fb = wb_data;
			default:  fb = rs2_data;
		endcase
	end

	pc_adder u_pc_adder (
		.instr(d_instr),
		.pc(d_pc),
		.rs1(rs1_data),
		.rs2(rs2_data),
		.ex_data(ex_data),
		.wb_data(wb_data),
		.fwd_rs1(fwd_rs1),
		.fwd_rs2(fwd_rs2),
		.pc_bj(pc_bj),
		.pc_sel(bj_sel),
		.branch_taken()
	);

	assign pc_sel = d_valid && bj_sel;

	// ecall only, ebreak falls through as a no-op
	assign halt_seen = d_valid && opcode == SYSTEM && d_instr.funct3 == 3'b000
		&& {d_instr.funct7, d_instr.rs2, d_instr.rs1, d_instr.rd} == '0;

	always_comb begin
		alu_op = ALU_ADD;
		we = 1'b0;
		op_a = fa;
		op_b = fb;
		case (opcode)
			OP: begin
				we = d_instr.funct3 == 3'b000
					&& (d_instr.funct7 == 7'h00 || d_instr.funct7 == 7'h20);
				if (d_instr.funct7 == 7'h20)
					alu_op = ALU_SUB;
			end
			OP_IMM: begin
				we = d_instr.funct3 == 3'b000; // addi
				op_b = get_imm_i(d_instr);
			end
			LUI: begin
				we = 1'b1;
				alu_op = ALU_PASS_B;
				op_b = get_imm_u(d_instr);
			end
			JAL, JALR: begin
				we = 1'b1;
				alu_op = ALU_LINK;
				op_a = d_pc; // link is pc+4
			end
			default: we = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			id_valid <= 1'b0;
			id_we <= 1'b0;
		end else begin
			id_valid <= d_valid;
			id_we <= we; // qualified by id_valid in execute
		end
		id_alu_op <= alu_op;
		id_rd <= d_instr.rd;
		id_op_a <= op_a;
		id_op_b <= op_b;
	end

endmodule

// File: design/pc_adder.sv
`timescale 1ns/1ps

module pc_adder (
	input defines::instr_t instr,
	input defines::data_t pc,
	input defines::data_t rs1,
	input defines::data_t rs2,
	input defines::data_t ex_data,
	input defines::data_t wb_data,
	input defines::branch_fwd_t fwd_rs1,
	input defines::branch_fwd_t fwd_rs2,
	output defines::data_t pc_bj,
	output logic pc_sel,
	output logic branch_taken
);
	import defines::*;

	opcode_t opcode;
	funct3_t funct3;
	data_t op1, op2;
	logic [XLEN:0] diff_s, diff_u;
	logic eq, lt, ltu;
	logic cond;
	data_t base, imm, sum;

	assign opcode = opcode_t'(instr.opcode);
	assign funct3 = funct3_t'(instr.funct3);

	always_comb begin
		case (fwd_rs1)
			B_EX_SEL: op1 = ex_data;
			B_WB_SEL: op1 = wb_data;
			default:  op1 = rs1;
		endcase
		case (fwd_rs2)
			B_EX_SEL: op2 = ex_data;
			B_WB_SEL: op2 = wb_data;
			default:  op2 = rs2;
		endcase
	end

	// 33 bit differences, top bit is the sign / borrow
	assign diff_s = {op1[XLEN-1], op1} - {op2[XLEN-1], op2};
	assign diff_u = {1'b0, op1} - {1'b0, op2};
	assign eq = (diff_u[XLEN-1:0] == '0);
	assign lt = diff_s[XLEN];
	assign ltu = diff_u[XLEN];

	always_comb begin
		case (funct3)
			BEQ:     cond = eq;
			BNE:     cond = !eq;
			BLT:     cond = lt;
			BGE:     cond = !lt;
			BLTU:    cond = ltu;
			BGEU:    cond = !ltu;
			default: cond = 1'b0;
		endcase
		branch_taken = cond && (opcode == B);
	end

	// jalr adds to rs1, everything else to pc
	always_comb begin
		base = (opcode == JALR) ? op1 : pc;
		case (opcode)
			B:       imm = get_imm_b(instr);
			JAL:     imm = get_imm_j(instr);
			JALR:    imm = get_imm_i(instr);
			default: imm = NULL;
		endcase
	end

	assign sum = base + imm;
	assign pc_bj = (opcode == JALR) ? {sum[XLEN-1:1], 1'b0} : sum;

	assign pc_sel = branch_taken || (opcode == JAL) || (opcode == JALR);

endmodule

// File: design/defines.sv
package defines;

	localparam int XLEN = 32;
	localparam int REGS = 32;
	localparam int IMEM_WORDS = 64;
	localparam int IMEM_AW = $clog2(IMEM_WORDS);

	typedef logic [XLEN-1:0] data_t;
	typedef logic [4:0] reg_addr_t;

	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t rs2;
		reg_addr_t rs1;
		logic [2:0] funct3;
		reg_addr_t rd;
		logic [6:0] opcode;
	} instr_t;

	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		B      = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		SYSTEM = 7'b1110011
	} opcode_t;

	typedef enum logic [2:0] {
		BEQ  = 3'b000,
		BNE  = 3'b001,
		BLT  = 3'b100,
		BGE  = 3'b101,
		BLTU = 3'b110,
		BGEU = 3'b111
	} funct3_t;

	// operand source for branch unit and alu
	typedef enum logic [1:0] {
		B_RS_SEL = 2'b00,
		B_EX_SEL = 2'b01,
		B_WB_SEL = 2'b10
	} branch_fwd_t;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_PASS_B,
		ALU_LINK
	} alu_op_t;

	// apb map, byte addresses
	localparam logic [11:0] IMEM_BASE = 12'h000;
	localparam logic [11:0] CTRL_ADDR = 12'h100;
	localparam logic [11:0] STATUS_ADDR = 12'h104;
	localparam logic [11:0] REG_BASE = 12'h180;

	localparam data_t NULL = '0;

	function automatic data_t get_imm_i(input instr_t i);
		return {{21{i[31]}}, i[30:20]};
	endfunction

	function automatic data_t get_imm_b(input instr_t i);
		return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0}; // half-word units
	endfunction

	function automatic data_t get_imm_j(input instr_t i);
		return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
	endfunction

	function automatic data_t get_imm_u(input instr_t i);
		return {i[31:12], 12'b0};
	endfunction

endpackage
